//--- rv_cases.txt
# I word: program words from the reset PC, four per line
# S addr data strobe: expected stores in order; H pc: address of the ECALL
I 123450b7 I 67808093 I 10102023 I ffb00113
I 402081b3 I 0ff1c193 I 10302223 I 00312213
I 0020b2b3 I 005204b3 I 00909333 I 10602423
I 40115393 I 00915433 I 10702623 I 10802823
I 12100023 I 121000a3 I 12100123 I 121001a3
I 12101223 I 12101323 I 00114463 I 00150513
I 00116463 I 00250513 I 00117463 I 00450513
I 00115463 I 00850513 I 12a02423 I 00300593
I 00160613 I feb61ee3 I 12c02623 I 0080076f
I 1e102823 I 12e02823 I 011707e7 I 1e102823
I 12f02a23 I 00001817 I 13002c23 I 00508013
I 12002e23 I 00000073
S 00000100 12345678 f  S 00000104 12345682 f
S 00000108 48d159e0 f  S 0000010c fffffffd f
S 00000110 3ffffffe f
S 00000120 12345678 1  S 00000120 34567800 2
S 00000120 56780000 4  S 00000120 78000000 8
S 00000124 12345678 3  S 00000124 56780000 c
S 00000128 0000000a f  S 0000012c 00000003 f
S 00000130 00000090 f  S 00000134 0000009c f
S 00000138 000010a4 f  S 0000013c 00000000 f
H 000000b4

//--- project.f
+incdir+.
rv_pkg.sv
rv_decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary -j 0 --top-module tb_rv_core -f project.f -o sim_tb_rv_core &&
  ./obj_dir/sim_tb_rv_core ||
  { echo "build or simulation failed"; exit 1; }

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_core;

  logic            clk;
  logic            rst;
  logic            imem_req;
  rv_pkg::word_t   imem_addr;
  rv_pkg::word_t   imem_data;
  rv_pkg::word_t   dmem_addr;
  rv_pkg::word_t   dmem_wdata;
  rv_pkg::strobe_t dmem_strobe;
  logic            halt;

  // Program image and expected results from the cases file
  rv_pkg::word_t   prog [$];
  rv_pkg::word_t   exp_addr [$];
  rv_pkg::word_t   exp_data [$];
  rv_pkg::strobe_t exp_strobe [$];
  rv_pkg::word_t   halt_pc;

  int store_idx;
  int cycle_count;
  int cycle_limit;
  bit after_rst;
  bit fetch_seen;

  rv_core rv_core_i (
    .clk         (clk),
    .rst         (rst),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_strobe (dmem_strobe),
    .halt        (halt)
  );

  always #5 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic compare_strobe(input string name, input rv_pkg::strobe_t got,
                                input rv_pkg::strobe_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic int word_index(input rv_pkg::word_t addr);
    return int'((addr - `RV_RESET_PC) >> 2);
  endfunction

  // Records tagged I word, S addr data strobe, H pc, or # for a comment line
  task automatic load_cases();
    int              fd;
    int              code;
    logic [7:0]      tag;
    string           rest;
    rv_pkg::word_t   a;
    rv_pkg::word_t   d;
    rv_pkg::strobe_t s;
    fd = $fopen("rv_cases.txt", "r");
    if (fd == 0) begin
      report_failure("could not open rv_cases.txt");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        case (tag)
          "#": code = $fgets(rest, fd);
          "I": begin
            code = $fscanf(fd, "%h", d);
            prog.push_back(d);
          end
          "S": begin
            code = $fscanf(fd, "%h %h %h", a, d, s);
            exp_addr.push_back(a);
            exp_data.push_back(d);
            exp_strobe.push_back(s);
          end
          "H": code = $fscanf(fd, "%h", halt_pc);
          default: report_failure("unknown record tag in rv_cases.txt");
        endcase
      end
      $fclose(fd);
    end
  endtask

  task automatic check_store();
    if (store_idx >= exp_addr.size()) begin
      report_failure($sformatf("store to %h beyond the expected list", dmem_addr));
    end else begin
      compare_word("dmem_addr", dmem_addr, exp_addr[store_idx]);
      compare_word("dmem_wdata", dmem_wdata, exp_data[store_idx]);
      compare_strobe("dmem_strobe", dmem_strobe, exp_strobe[store_idx]);
      store_idx++;
    end
  endtask

  // Instruction memory, reset checks, store checks and timeout
  always @(posedge clk) begin
    if (rst || after_rst) begin
      compare_strobe("dmem_strobe", dmem_strobe, '0);
      if (halt === 1'b1) begin
        report_failure("halt is high during or right after reset");
      end
    end
    if (rst && imem_req === 1'b1) begin
      report_failure("instruction fetch requested during reset");
    end
    after_rst <= rst;
    if (!rst && imem_req === 1'b1 && !fetch_seen) begin
      compare_word("imem_addr", imem_addr, `RV_RESET_PC);
      fetch_seen <= 1'b1;
    end
    if (imem_req === 1'b1) begin
      if (imem_addr[1:0] != 2'b00) begin
        report_failure($sformatf("fetch from unaligned address %h", imem_addr));
      end else if (word_index(imem_addr) >= prog.size()) begin
        report_failure($sformatf("fetch from %h outside the program", imem_addr));
      end else begin
        imem_data <= prog[word_index(imem_addr)];
      end
    end
    if (!rst && dmem_strobe != '0) begin
      check_store();
    end
    if (!rst) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        report_failure($sformatf("timeout, no halt after %0d cycles", cycle_count));
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst <= 1'b1;
    imem_data <= '0;
    load_cases();
    // Room for loop iterations on top of two cycles per word
    cycle_limit = 4 * (prog.size() + 1) * 8;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    while (halt !== 1'b1) begin
      @(posedge clk);
    end
    if (store_idx != exp_addr.size()) begin
      report_failure($sformatf("halted after %0d of %0d expected stores",
                               store_idx, exp_addr.size()));
    end else begin
      compare_word("imem_addr", imem_addr, halt_pc);
      // Core must stay parked on the ECALL
      repeat (3) begin
        @(posedge clk);
        if (halt !== 1'b1 || imem_req !== 1'b0) begin
          report_failure("core left halt or fetched again after ECALL");
        end
        compare_word("imem_addr", imem_addr, halt_pc);
      end
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core (
  input  logic            clk,
  input  logic            rst,
  output logic            imem_req,
  output rv_pkg::word_t   imem_addr,
  input  rv_pkg::word_t   imem_data,
  output rv_pkg::word_t   dmem_addr,
  output rv_pkg::word_t   dmem_wdata,
  output rv_pkg::strobe_t dmem_strobe,
  output logic            halt
);

  rv_pkg::core_state_t state;
  rv_pkg::word_t       pc;
  rv_pkg::word_t       next_pc;
  rv_pkg::word_t       rs1_data;
  rv_pkg::word_t       rs2_data;
  rv_pkg::word_t       rd_data;
  rv_pkg::strobe_t     store_strobe;
  logic                rd_we;
  logic                rf_we;
  logic                in_exec;

  rv_decode_if dec ();

  // Instruction word is valid during the execute cycle
  rv_decoder decoder_i (
    .insn (imem_data),
    .dec  (dec.decoder)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (dec.rd),
    .rd_data  (rd_data)
  );

  rv_execute execute_i (
    .dec          (dec.execute),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .next_pc      (next_pc),
    .rd_we        (rd_we),
    .rd_data      (rd_data),
    .store_addr   (dmem_addr),
    .store_data   (dmem_wdata),
    .store_strobe (store_strobe)
  );

  assign in_exec = (state == rv_pkg::st_exec);

  // Side effects only while an instruction executes
  assign rf_we       = rd_we && in_exec;
  assign dmem_strobe = in_exec ? store_strobe : '0;

  // No fetch request while reset is held
  assign imem_req  = (state == rv_pkg::st_fetch) && !rst;
  assign imem_addr = pc;
  assign halt      = (state == rv_pkg::st_halted);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::st_fetch;
      pc    <= `RV_RESET_PC;
    end else begin
      case (state)
        rv_pkg::st_fetch: begin
          state <= rv_pkg::st_exec;
        end
        rv_pkg::st_exec: begin
          if (dec.is_ecall) begin
            // PC stays on the ECALL
            state <= rv_pkg::st_halted;
          end else begin
            state <= rv_pkg::st_fetch;
            pc    <= next_pc;
          end
        end
        default: begin
          state <= rv_pkg::st_halted;
        end
      endcase
    end
  end

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_execute (
  rv_decode_if.execute    dec,
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  output rv_pkg::word_t   next_pc,
  output logic            rd_we,
  output rv_pkg::word_t   rd_data,
  output rv_pkg::word_t   store_addr,
  output rv_pkg::word_t   store_data,
  output rv_pkg::strobe_t store_strobe
);

  logic [2:0]    funct3;
  logic [4:0]    shamt;
  logic          branch_taken;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t sra_result;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_plus_imm;
  rv_pkg::word_t rs1_plus_imm;

  assign funct3       = dec.alu_op[2:0];
  assign alu_b        = dec.use_imm ? dec.imm : rs2_data;
  assign shamt        = alu_b[4:0];
  assign pc_plus4     = pc + 32'd4;
  assign pc_plus_imm  = pc + dec.imm;
  // Shared by JALR targets and store addresses
  assign rs1_plus_imm = rs1_data + dec.imm;

  // Arithmetic shift keeps the sign of rs1
  assign sra_result = $signed(rs1_data) >>> shamt;

  always_comb begin
    case (funct3)
      3'b000:  alu_result = dec.alu_op[3] ? rs1_data - alu_b : rs1_data + alu_b;
      3'b001:  alu_result = rs1_data << shamt;
      3'b010:  alu_result = {31'd0, $signed(rs1_data) < $signed(alu_b)};
      3'b011:  alu_result = {31'd0, rs1_data < alu_b};
      3'b100:  alu_result = rs1_data ^ alu_b;
      3'b101:  alu_result = dec.alu_op[3] ? sra_result : rs1_data >> shamt;
      3'b110:  alu_result = rs1_data | alu_b;
      default: alu_result = rs1_data & alu_b;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = (rs1_data == rs2_data);
      3'b001:  branch_taken = (rs1_data != rs2_data);
      3'b100:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  branch_taken = rs1_data < rs2_data;
      3'b111:  branch_taken = rs1_data >= rs2_data;
      default: branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = {rs1_plus_imm[31:1], 1'b0};
    end else if (dec.is_jal || (dec.is_branch && branch_taken)) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // Write-back select
  always_comb begin
    if (dec.is_lui) begin
      rd_data = dec.imm;
    end else if (dec.is_auipc) begin
      rd_data = pc_plus_imm;
    end else if (dec.is_jal || dec.is_jalr) begin
      rd_data = pc_plus4;
    end else begin
      rd_data = alu_result;
    end
  end

  assign rd_we = dec.reg_write;

  // Word-aligned address with lanes picked by the low two bits
  assign store_addr = {rs1_plus_imm[31:2], 2'b00};

  always_comb begin
    store_data   = rs2_data;
    store_strobe = '0;
    if (dec.is_store) begin
      case (funct3)
        `RV_F3_SB: begin
          store_strobe = 4'b0001 << rs1_plus_imm[1:0];
          store_data   = rs2_data << {rs1_plus_imm[1:0], 3'b000};
        end
        `RV_F3_SH: begin
          if (rs1_plus_imm[1]) begin
            store_strobe = 4'b1100;
            store_data   = rs2_data << 16;
          end else begin
            store_strobe = 4'b0011;
          end
        end
        default: begin
          store_strobe = 4'b1111;
        end
      endcase
    end
  end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data
);

  rv_pkg::word_t regs [`RV_NUM_REGS];

  // Asynchronous reads with x0 tied to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- rv_decoder.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decoder (
  input rv_pkg::word_t insn,
  rv_decode_if.decoder dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       writes_rd;

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_j;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // Immediate formats with the sign taken from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    dec.rs1       = insn[19:15];
    dec.rs2       = insn[24:20];
    dec.rd        = insn[11:7];
    dec.imm       = imm_i;
    dec.alu_op    = {insn[30], funct3};
    dec.use_imm   = 1'b0;
    dec.is_lui    = 1'b0;
    dec.is_auipc  = 1'b0;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    dec.is_branch = 1'b0;
    dec.is_store  = 1'b0;
    dec.is_ecall  = 1'b0;
    writes_rd     = 1'b0;

    case (opcode)
      `RV_OP_LUI: begin
        dec.is_lui = 1'b1;
        dec.imm    = imm_u;
        writes_rd  = 1'b1;
      end
      `RV_OP_AUIPC: begin
        dec.is_auipc = 1'b1;
        dec.imm      = imm_u;
        writes_rd    = 1'b1;
      end
      `RV_OP_JAL: begin
        dec.is_jal = 1'b1;
        dec.imm    = imm_j;
        writes_rd  = 1'b1;
      end
      `RV_OP_JALR: begin
        dec.is_jalr = 1'b1;
        writes_rd   = 1'b1;
      end
      `RV_OP_BRANCH: begin
        dec.is_branch = 1'b1;
        dec.imm       = imm_b;
      end
      `RV_OP_STORE: begin
        // Other widths fall through as no-ops
        dec.is_store = (funct3 == `RV_F3_SB) || (funct3 == `RV_F3_SH) ||
                       (funct3 == `RV_F3_SW);
        dec.imm      = imm_s;
      end
      `RV_OP_IMM: begin
        dec.use_imm = 1'b1;
        writes_rd   = 1'b1;
        // insn[30] belongs to the immediate except on SRAI
        dec.alu_op  = {insn[30] && (funct3 == 3'b101), funct3};
      end
      `RV_OP_REG: begin
        // Base ISA only, so M-extension words do nothing
        writes_rd = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
      end
      `RV_OP_SYSTEM: begin
        dec.is_ecall = (insn[31:7] == 25'd0);
      end
      default: begin
        writes_rd = 1'b0;
      end
    endcase

    // Writes to x0 are dropped here
    dec.reg_write = writes_rd && (insn[11:7] != 5'd0);
  end

endmodule

//--- rv_decode_if.sv
`timescale 1ns/1ps

interface rv_decode_if;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm;
  rv_pkg::alu_op_t  alu_op;

  // Control flags for the execute stage
  logic use_imm;
  logic reg_write;
  logic is_lui;
  logic is_auipc;
  logic is_jal;
  logic is_jalr;
  logic is_branch;
  logic is_store;
  logic is_ecall;

  modport decoder (
    output rs1, rs2, rd, imm, alu_op,
    output use_imm, reg_write, is_lui, is_auipc, is_jal, is_jalr,
    output is_branch, is_store, is_ecall
  );

  modport execute (
    input rs1, rs2, rd, imm, alu_op,
    input use_imm, reg_write, is_lui, is_auipc, is_jal, is_jalr,
    input is_branch, is_store, is_ecall
  );

endinterface

//--- rv_pkg.sv
package rv_pkg;

  // Register contents and byte addresses
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

  // One write enable per byte lane of a store
  typedef logic [3:0] strobe_t;

  // Alternate bit (insn[30]) on top of funct3
  typedef logic [3:0] alu_op_t;

  // Two-cycle sequencing of the core
  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_halted
  } core_state_t;

endpackage

//--- rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Reset vector and architectural register count
`define RV_RESET_PC 32'h0000_0000
`define RV_NUM_REGS 32

// Major opcodes in instruction bits 6:0
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

// Store width in funct3
`define RV_F3_SB 3'b000
`define RV_F3_SH 3'b001
`define RV_F3_SW 3'b010

`endif
